// ==== Makefile ====
# Verilator build and run of the vector register file testbench

VERILATOR ?= verilator
TOP       ?= tb_vrf
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^TB PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== source/bank_wr_if.sv ====
`timescale 1ns/100ps
`include "vrf_config.svh"

interface bank_wr_if;

   // raw write address, used to look up the other banks
   vrf_pkg::addr_t [`VRF_W_PORTS-1:0] lkp_addr;

   // lkp_data[c][b] is the word of bank b seen by bank c
   // entry [c][c] is always zero
   vrf_pkg::word_arr_t [`VRF_W_PORTS-1:0] lkp_data;

   // registered write, one entry per bank
   vrf_pkg::addr_t [`VRF_W_PORTS-1:0] wr_addr;
   logic [`VRF_W_PORTS-1:0]           wr_en;
   vrf_pkg::word_arr_t                wr_data;

   modport producer (
      output lkp_addr,
      input  lkp_data,
      output wr_addr,
      output wr_en,
      output wr_data
   );

   modport buffer (
      input  lkp_addr,
      output lkp_data,
      input  wr_addr,
      input  wr_en,
      input  wr_data
   );

endinterface

// ==== source/sdp_distram.sv ====
`timescale 1ns/100ps
`include "vrf_config.svh"

module sdp_distram #(
   parameter int DEPTH = `VRF_DEPTH,
   parameter int WIDTH = `VRF_WIDTH
)
(
   input  logic           clk,
   input  logic           rstn,
   input  logic           wr_en_i,
   input  vrf_pkg::addr_t wr_addr_i,
   input  vrf_pkg::word_t wr_data_i,
   input  logic           rd_en_i,
   input  vrf_pkg::addr_t rd_addr_i,
   output vrf_pkg::word_t rd_data_o
);

   // lut storage starts out all zero
   logic [WIDTH-1:0] mem [DEPTH] = '{default: '0};

   always_ff @(posedge clk)
   begin
      if (wr_en_i)
      begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // output register holds its word while rd_en_i is low
   // a read at the write edge still returns the old word
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         rd_data_o <= '0;
      end
      else if (rd_en_i)
      begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

// ==== source/vrf.sv ====
`timescale 1ns/100ps
`include "vrf_config.svh"

module vrf (
   input  logic                              clk,
   input  logic                              rstn,

   // write ports
   input  logic [`VRF_W_PORTS-1:0]           wen_i,
   input  vrf_pkg::addr_t [`VRF_W_PORTS-1:0] waddr_i,
   input  vrf_pkg::word_arr_t                din_i,

   // read ports, one cycle latency
   input  logic [`VRF_R_PORTS-1:0]           ren_i,
   input  vrf_pkg::addr_t [`VRF_R_PORTS-1:0] raddr_i,
   output vrf_pkg::word_t [`VRF_R_PORTS-1:0] dout_o
);

   // raw bank outputs, [read port][bank]
   vrf_pkg::word_arr_t [`VRF_R_PORTS-1:0] bank_rdata;

   bank_wr_if bank_wr ();

   xor_write_encoder u_encoder (
      .clk     (clk),
      .rstn    (rstn),
      .wen_i   (wen_i),
      .waddr_i (waddr_i),
      .din_i   (din_i),
      .wr      (bank_wr.producer)
   );

   xor_bank_array u_banks (
      .clk          (clk),
      .rstn         (rstn),
      .wr           (bank_wr.buffer),
      .ren_i        (ren_i),
      .raddr_i      (raddr_i),
      .bank_rdata_o (bank_rdata)
   );

   xor_read_decoder u_decoder (
      .bank_rdata_i (bank_rdata),
      .dout_o       (dout_o)
   );

endmodule

// ==== source/vrf_config.svh ====
`ifndef VRF_CONFIG_SVH
`define VRF_CONFIG_SVH

// number of words held by the register file
`define VRF_DEPTH 32

// word width in bits
`define VRF_WIDTH 16

// write ports, one bank per write port
`define VRF_W_PORTS 2

// independent read ports
`define VRF_R_PORTS 2

// address width follows the depth
`define VRF_ADDR_W ($clog2(`VRF_DEPTH))

`endif

// ==== source/vrf_pkg.sv ====
`include "vrf_config.svh"

package vrf_pkg;

   // word address into any bank
   typedef logic [`VRF_ADDR_W-1:0] addr_t;

   // one register word
   typedef logic [`VRF_WIDTH-1:0] word_t;

   // one word per bank
   typedef word_t [`VRF_W_PORTS-1:0] word_arr_t;

endpackage

// ==== source/xor_bank_array.sv ====
`timescale 1ns/100ps
`include "vrf_config.svh"

module xor_bank_array (
   input  logic                                  clk,
   input  logic                                  rstn,
   bank_wr_if.buffer                             wr,
   input  logic [`VRF_R_PORTS-1:0]               ren_i,
   input  vrf_pkg::addr_t [`VRF_R_PORTS-1:0]     raddr_i,
   output vrf_pkg::word_arr_t [`VRF_R_PORTS-1:0] bank_rdata_o
);

   for (genvar b = 0; b < `VRF_W_PORTS; b++)
   begin : g_bank

      // lookup copies of bank b, one for every other bank c
      for (genvar c = 0; c < `VRF_W_PORTS; c++)
      begin : g_lkp
         if (c != b)
         begin : g_copy
            sdp_distram #(
               .DEPTH (`VRF_DEPTH),
               .WIDTH (`VRF_WIDTH)
            ) u_lkp_ram (
               .clk       (clk),
               .rstn      (rstn),
               .wr_en_i   (wr.wr_en[b]),
               .wr_addr_i (wr.wr_addr[b]),
               .wr_data_i (wr.wr_data[b]),
               // lookup runs every cycle
               .rd_en_i   (1'b1),
               .rd_addr_i (wr.lkp_addr[c]),
               .rd_data_o (wr.lkp_data[c][b])
            );
         end
         else
         begin : g_self
            // a bank never needs its own contents
            assign wr.lkp_data[b][b] = '0;
         end
      end

      // read copies of bank b, one per read port
      for (genvar r = 0; r < `VRF_R_PORTS; r++)
      begin : g_rd
         sdp_distram #(
            .DEPTH (`VRF_DEPTH),
            .WIDTH (`VRF_WIDTH)
         ) u_rd_ram (
            .clk       (clk),
            .rstn      (rstn),
            .wr_en_i   (wr.wr_en[b]),
            .wr_addr_i (wr.wr_addr[b]),
            .wr_data_i (wr.wr_data[b]),
            .rd_en_i   (ren_i[r]),
            .rd_addr_i (raddr_i[r]),
            .rd_data_o (bank_rdata_o[r][b])
         );
      end

   end

endmodule

// ==== source/xor_read_decoder.sv ====
`timescale 1ns/100ps
`include "vrf_config.svh"

module xor_read_decoder (
   input  vrf_pkg::word_arr_t [`VRF_R_PORTS-1:0] bank_rdata_i,
   output vrf_pkg::word_t [`VRF_R_PORTS-1:0]     dout_o
);

   // xor across all banks cancels the encoding
   // and leaves the last word written to that address
   always_comb
   begin
      for (int r = 0; r < `VRF_R_PORTS; r++)
      begin
         dout_o[r] = '0;
         for (int b = 0; b < `VRF_W_PORTS; b++)
         begin
            dout_o[r] = dout_o[r] ^ bank_rdata_i[r][b];
         end
      end
   end

endmodule

// ==== source/xor_write_encoder.sv ====
`timescale 1ns/100ps
`include "vrf_config.svh"

module xor_write_encoder (
   input  logic                              clk,
   input  logic                              rstn,
   input  logic [`VRF_W_PORTS-1:0]           wen_i,
   input  vrf_pkg::addr_t [`VRF_W_PORTS-1:0] waddr_i,
   input  vrf_pkg::word_arr_t                din_i,
   bank_wr_if.producer                       wr
);

   logic [`VRF_W_PORTS-1:0]           wen_q;
   vrf_pkg::addr_t [`VRF_W_PORTS-1:0] waddr_q;
   vrf_pkg::word_arr_t                din_q;

   // registered write strobes
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         wen_q <= '0;
      end
      else
      begin
         wen_q <= wen_i;
      end
   end

   always_ff @(posedge clk)
   begin
      waddr_q <= waddr_i;
      din_q   <= din_i;
   end

   // lookups start from the raw address
   // so their result lines up with the registered request
   assign wr.lkp_addr = waddr_i;

   assign wr.wr_en   = wen_q;
   assign wr.wr_addr = waddr_q;

   // bank c stores din ^ (all other banks at that address)
   always_comb
   begin
      for (int c = 0; c < `VRF_W_PORTS; c++)
      begin
         wr.wr_data[c] = din_q[c];
         for (int b = 0; b < `VRF_W_PORTS; b++)
         begin
            wr.wr_data[c] = wr.wr_data[c] ^ wr.lkp_data[c][b];
         end
      end
   end

endmodule

// ==== tb/clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen #(
   parameter int PERIOD       = 40,
   parameter int RESET_CYCLES = 16
)
(
   output logic clk,
   output logic rstn
);

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(PERIOD / 2) clk = ~clk;
      end
   end

   // release on a falling edge away from the sampling edge
   initial
   begin
      rstn = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
   end

endmodule

// ==== tb/tb_vrf.sv ====
`timescale 1ns/100ps
`include "vrf_config.svh"

module tb_vrf;

   localparam int    RESET_CYCLES = 16;
   localparam string DATA_FILE    = "tb/vrf_testdata.txt";

   logic                              clk;
   logic                              rstn;
   logic [`VRF_W_PORTS-1:0]           wen;
   vrf_pkg::addr_t [`VRF_W_PORTS-1:0] waddr;
   vrf_pkg::word_arr_t                din;
   logic [`VRF_R_PORTS-1:0]           ren;
   vrf_pkg::addr_t [`VRF_R_PORTS-1:0] raddr;
   vrf_pkg::word_t [`VRF_R_PORTS-1:0] dout;

   // one entry per data line
   logic [`VRF_W_PORTS-1:0]           stim_wen [$];
   vrf_pkg::addr_t [`VRF_W_PORTS-1:0] stim_waddr [$];
   vrf_pkg::word_arr_t                stim_din [$];
   logic [`VRF_R_PORTS-1:0]           stim_ren [$];
   vrf_pkg::addr_t [`VRF_R_PORTS-1:0] stim_raddr [$];
   logic [`VRF_R_PORTS-1:0]           exp_chk [$];
   vrf_pkg::word_t [`VRF_R_PORTS-1:0] exp_dout [$];

   int cycle_count   = 0;
   int timeout_limit = RESET_CYCLES + 20;

   clk_gen #(
      .PERIOD       (40),
      .RESET_CYCLES (RESET_CYCLES)
   ) u_clk_gen (
      .clk  (clk),
      .rstn (rstn)
   );

   vrf UUT (
      .clk     (clk),
      .rstn    (rstn),
      .wen_i   (wen),
      .waddr_i (waddr),
      .din_i   (din),
      .ren_i   (ren),
      .raddr_i (raddr),
      .dout_o  (dout)
   );

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("TB FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_value(input string name, input vrf_pkg::word_t actual,
                              input vrf_pkg::word_t expected);
      if (actual !== expected)
      begin
         fail_run($sformatf("mismatch %s: actual 0x%h, expected 0x%h",
                            name, actual, expected));
      end
   endtask

   // data file columns wen0 waddr0 din0 wen1 waddr1 din1 ren0 raddr0 ren1 raddr1
   // then chk0 exp0 chk1 exp1
   task automatic load_test_data();
      int                                fd;
      int                                n;
      string                             text;
      logic [31:0]                       f [14];
      logic [`VRF_W_PORTS-1:0]           wen_v;
      vrf_pkg::addr_t [`VRF_W_PORTS-1:0] waddr_v;
      vrf_pkg::word_arr_t                din_v;
      logic [`VRF_R_PORTS-1:0]           ren_v;
      vrf_pkg::addr_t [`VRF_R_PORTS-1:0] raddr_v;
      logic [`VRF_R_PORTS-1:0]           chk_v;
      vrf_pkg::word_t [`VRF_R_PORTS-1:0] exp_v;
      fd = $fopen(DATA_FILE, "r");
      if (fd == 0)
      begin
         fail_run({"cannot open the test data file ", DATA_FILE});
      end
      while (!$feof(fd))
      begin
         text = "";
         void'($fgets(text, fd));
         if (text.len() == 0 || text.substr(0, 0) == "#")
         begin
            continue;
         end
         n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                     f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
         if (n == 14)
         begin
            wen_v[0]   = f[0][0];
            waddr_v[0] = vrf_pkg::addr_t'(f[1]);
            din_v[0]   = vrf_pkg::word_t'(f[2]);
            wen_v[1]   = f[3][0];
            waddr_v[1] = vrf_pkg::addr_t'(f[4]);
            din_v[1]   = vrf_pkg::word_t'(f[5]);
            ren_v[0]   = f[6][0];
            raddr_v[0] = vrf_pkg::addr_t'(f[7]);
            ren_v[1]   = f[8][0];
            raddr_v[1] = vrf_pkg::addr_t'(f[9]);
            chk_v[0]   = f[10][0];
            exp_v[0]   = vrf_pkg::word_t'(f[11]);
            chk_v[1]   = f[12][0];
            exp_v[1]   = vrf_pkg::word_t'(f[13]);
            stim_wen.push_back(wen_v);
            stim_waddr.push_back(waddr_v);
            stim_din.push_back(din_v);
            stim_ren.push_back(ren_v);
            stim_raddr.push_back(raddr_v);
            exp_chk.push_back(chk_v);
            exp_dout.push_back(exp_v);
         end
         else if (n > 0)
         begin
            fail_run({"the test data file has a line with too few columns: ", text});
         end
      end
      $fclose(fd);
      if (stim_wen.size() == 0)
      begin
         fail_run("the test data file holds no test lines");
      end
   endtask

   task automatic apply_line(input int i);
      wen   = stim_wen[i];
      waddr = stim_waddr[i];
      din   = stim_din[i];
      ren   = stim_ren[i];
      raddr = stim_raddr[i];
   endtask

   // read data of line i is valid one falling edge after it was driven
   task automatic verify_reads(input int i);
      for (int r = 0; r < `VRF_R_PORTS; r++)
      begin
         if (exp_chk[i][r])
         begin
            check_value($sformatf("dout_o[%0d]", r), dout[r], exp_dout[i][r]);
         end
      end
   endtask

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= timeout_limit)
      begin
         fail_run($sformatf("timeout: the run did not finish within %0d cycles",
                            timeout_limit));
      end
   end

   initial
   begin
      wen   = '0;
      waddr = '0;
      din   = '0;
      ren   = '0;
      raddr = '0;
      wait (rstn === 1'b1);
      load_test_data();
      timeout_limit = RESET_CYCLES + stim_wen.size() + 20;
      @(negedge clk);
      for (int i = 0; i < stim_wen.size(); i++)
      begin
         apply_line(i);
         @(negedge clk);
         verify_reads(i);
      end
      wen = '0;
      ren = '0;
      $display("TB PASSED");
      $finish;
   end

endmodule

// ==== tb/vrf_testdata.txt ====
# wen0 waddr0 din0 wen1 waddr1 din1 ren0 raddr0 ren1 raddr1 chk0 exp0 chk1 exp1
# one line per cycle, all hex, expected words are checked one cycle later
# reads after reset
0 00 0000 0 00 0000 1 00 1 1f 1 0000 1 0000
0 00 0000 0 00 0000 1 05 1 0a 1 0000 1 0000
# port 0 write, old value one edge later, new value after two
1 03 1234 0 00 0000 1 03 1 03 1 0000 1 0000
0 00 0000 0 00 0000 1 03 1 03 1 0000 1 0000
0 00 0000 0 00 0000 1 03 1 03 1 1234 1 1234
# port 1 write
0 00 0000 1 07 abcd 1 07 1 07 1 0000 1 0000
0 00 0000 0 00 0000 1 03 1 07 1 1234 1 0000
0 00 0000 0 00 0000 1 07 1 07 1 abcd 1 abcd
# both ports write in one cycle
1 10 5a5a 1 11 c3c3 1 03 1 07 1 1234 1 abcd
1 07 1111 1 03 2222 1 10 1 11 1 0000 1 0000
0 00 0000 0 00 0000 1 10 1 11 1 5a5a 1 c3c3
0 00 0000 0 00 0000 1 07 1 03 1 1111 1 2222
0 00 0000 0 00 0000 1 11 1 10 1 c3c3 1 5a5a
# port 1 overwrites a port 0 word, then port 0 takes it back
0 00 0000 1 10 7e7e 1 10 1 10 1 5a5a 1 5a5a
0 00 0000 0 00 0000 1 10 1 10 1 5a5a 1 5a5a
1 10 0101 0 00 0000 1 10 1 10 1 7e7e 1 7e7e
0 00 0000 0 00 0000 1 10 1 10 1 7e7e 1 7e7e
0 00 0000 0 00 0000 1 10 1 10 1 0101 1 0101
# outputs hold while ren is low
0 00 0000 0 00 0000 1 07 1 03 1 1111 1 2222
1 07 4444 1 03 5555 0 00 0 00 1 1111 1 2222
0 00 0000 0 00 0000 0 00 0 00 1 1111 1 2222
0 00 0000 0 00 0000 0 15 0 15 1 1111 1 2222
0 00 0000 0 00 0000 1 07 1 03 1 4444 1 5555
0 00 0000 0 00 0000 0 00 1 07 1 4444 1 4444
0 00 0000 0 00 0000 1 1f 0 00 1 0000 1 4444
# first and last address
1 1f ffff 1 00 8001 1 1f 1 00 1 0000 1 0000
0 00 0000 0 00 0000 1 1f 1 00 1 0000 1 0000
0 00 0000 0 00 0000 1 1f 1 00 1 ffff 1 8001
1 00 3c3c 0 00 0000 1 00 1 1f 1 8001 1 ffff
0 00 0000 0 00 0000 1 00 1 00 1 8001 1 8001
0 00 0000 0 00 0000 1 00 1 00 1 3c3c 1 3c3c
0 00 0000 0 00 0000 0 00 0 00 0 0000 0 0000

// ==== verilog.f ====
+incdir+source
source/vrf_pkg.sv
source/bank_wr_if.sv
source/sdp_distram.sv
source/xor_write_encoder.sv
source/xor_bank_array.sv
source/xor_read_decoder.sv
source/vrf.sv
tb/clk_gen.sv
tb/tb_vrf.sv
